/* common/vec_pkg.sv */
package vec_pkg;

    // ##################################################################
    // Sizes
    // ##################################################################

    localparam int DWIDTH = 32;               // Element width.
    localparam int LANES  = 4;
    localparam int VWIDTH = DWIDTH * LANES;   // Whole vector register.
    localparam int NREGS  = 8;
    localparam int RIDX_W = 3;
    localparam int ILEN   = 32;               // Instruction word.
    localparam int OP_W   = 5;
    localparam int IMM_W  = 21;

    // ##################################################################
    // Opcodes, bits 31:27 of the instruction
    // ##################################################################

    localparam logic [OP_W-1:0] OP_NOP  = 5'd0;
    localparam logic [OP_W-1:0] OP_LDI  = 5'd1;   // Immediate form.
    localparam logic [OP_W-1:0] OP_ADDI = 5'd2;   // Immediate form.
    localparam logic [OP_W-1:0] OP_ADD  = 5'd3;
    localparam logic [OP_W-1:0] OP_SUB  = 5'd4;
    localparam logic [OP_W-1:0] OP_MUL  = 5'd5;
    localparam logic [OP_W-1:0] OP_DIV  = 5'd6;
    localparam logic [OP_W-1:0] OP_AND  = 5'd7;
    localparam logic [OP_W-1:0] OP_OR   = 5'd8;
    localparam logic [OP_W-1:0] OP_SHL  = 5'd9;
    localparam logic [OP_W-1:0] OP_SHR  = 5'd10;
    localparam logic [OP_W-1:0] OP_CMP  = 5'd11;
    localparam logic [OP_W-1:0] OP_NOT  = 5'd12;

    // ##################################################################
    // Instruction word
    // ##################################################################

    // Opcode sits in the same bits for both views.
    typedef union packed {
        struct packed {
            logic [OP_W-1:0]                 opcode;
            logic [RIDX_W-1:0]               rd;
            logic [RIDX_W-1:0]               ra;
            logic [RIDX_W-1:0]               rb;
            logic [ILEN-OP_W-3*RIDX_W-1:0]   unused;
        } rform;
        struct packed {
            logic [OP_W-1:0]                 opcode;
            logic [RIDX_W-1:0]               rd;
            logic [RIDX_W-1:0]               ra;
            logic [IMM_W-1:0]                imm;    // Signed.
        } iform;
    } instr_t;

endpackage

/* logic/vec_alu_top.sv */
`timescale 1ns/1ps

module vec_alu_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          instr_valid,
    input  logic [vec_pkg::ILEN-1:0]      instr,
    output logic                          done,
    output logic [vec_pkg::RIDX_W-1:0]    done_rd,
    output logic [vec_pkg::VWIDTH-1:0]    done_result,
    output logic [vec_pkg::LANES-1:0]     below_mask,
    output logic [vec_pkg::LANES-1:0]     equal_mask,
    output logic [vec_pkg::LANES-1:0]     above_mask,
    output logic                          div_error,
    output logic                          illegal
);

    localparam int DW = vec_pkg::DWIDTH;

    logic [vec_pkg::RIDX_W-1:0]   ra_idx;
    logic [vec_pkg::RIDX_W-1:0]   rb_idx;
    logic [vec_pkg::VWIDTH-1:0]   ra_data;
    logic [vec_pkg::VWIDTH-1:0]   rb_data;
    logic                         op_valid;
    logic [vec_pkg::OP_W-1:0]     op_code;
    logic [vec_pkg::VWIDTH-1:0]   opa;
    logic [vec_pkg::VWIDTH-1:0]   opb;
    logic [vec_pkg::RIDX_W-1:0]   wb_rd;
    logic                         wb_write;
    logic                         wb_cmp;
    logic                         wb_illegal;
    logic [vec_pkg::LANES-1:0]    res_valid;
    logic [vec_pkg::VWIDTH-1:0]   lane_res;
    logic [vec_pkg::LANES-1:0]    lane_below;
    logic [vec_pkg::LANES-1:0]    lane_equal;
    logic [vec_pkg::LANES-1:0]    lane_above;
    logic [vec_pkg::LANES-1:0]    lane_div_zero;
    logic                         we;
    logic [vec_pkg::RIDX_W-1:0]   wr_idx;
    logic [vec_pkg::VWIDTH-1:0]   wr_data;

    vec_issue i_vec_issue (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .ra_data     (ra_data),
        .rb_data     (rb_data),
        .ra_idx      (ra_idx),
        .rb_idx      (rb_idx),
        .op_valid    (op_valid),
        .op_code     (op_code),
        .opa         (opa),
        .opb         (opb),
        .wb_rd       (wb_rd),
        .wb_write    (wb_write),
        .wb_cmp      (wb_cmp),
        .wb_illegal  (wb_illegal)
    );

    vec_regfile i_vec_regfile (
        .clk     (clk),
        .rst     (rst),
        .ra_idx  (ra_idx),
        .rb_idx  (rb_idx),
        .we      (we),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .ra_data (ra_data),
        .rb_data (rb_data)
    );

    // One lane per element slice.
    for (genvar i = 0; i < vec_pkg::LANES; i++) begin : g_lane
        vec_lane i_vec_lane (
            .clk       (clk),
            .rst       (rst),
            .op_valid  (op_valid),
            .op_code   (op_code),
            .opa       (opa[i*DW +: DW]),
            .opb       (opb[i*DW +: DW]),
            .res_valid (res_valid[i]),
            .res       (lane_res[i*DW +: DW]),
            .below     (lane_below[i]),
            .equal     (lane_equal[i]),
            .above     (lane_above[i]),
            .div_zero  (lane_div_zero[i])
        );
    end

    vec_writeback i_vec_writeback (
        .clk           (clk),
        .rst           (rst),
        .res_valid     (res_valid),
        .lane_res      (lane_res),
        .lane_below    (lane_below),
        .lane_equal    (lane_equal),
        .lane_above    (lane_above),
        .lane_div_zero (lane_div_zero),
        .wb_rd         (wb_rd),
        .wb_write      (wb_write),
        .wb_cmp        (wb_cmp),
        .wb_illegal    (wb_illegal),
        .we            (we),
        .wr_idx        (wr_idx),
        .wr_data       (wr_data),
        .done          (done),
        .done_rd       (done_rd),
        .done_result   (done_result),
        .below_mask    (below_mask),
        .equal_mask    (equal_mask),
        .above_mask    (above_mask),
        .div_error     (div_error),
        .illegal       (illegal)
    );

endmodule

/* logic/vec_issue.sv */
`timescale 1ns/1ps

module vec_issue (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          instr_valid,
    input  logic [vec_pkg::ILEN-1:0]      instr,
    input  logic [vec_pkg::VWIDTH-1:0]    ra_data,
    input  logic [vec_pkg::VWIDTH-1:0]    rb_data,
    output logic [vec_pkg::RIDX_W-1:0]    ra_idx,
    output logic [vec_pkg::RIDX_W-1:0]    rb_idx,
    output logic                          op_valid,
    output logic [vec_pkg::OP_W-1:0]      op_code,
    output logic [vec_pkg::VWIDTH-1:0]    opa,
    output logic [vec_pkg::VWIDTH-1:0]    opb,
    output logic [vec_pkg::RIDX_W-1:0]    wb_rd,
    output logic                          wb_write,
    output logic                          wb_cmp,
    output logic                          wb_illegal
);

    vec_pkg::instr_t              ins;
    logic [vec_pkg::OP_W-1:0]     opc;
    logic [vec_pkg::DWIDTH-1:0]   imm32;
    logic [vec_pkg::VWIDTH-1:0]   imm_vec;
    logic [vec_pkg::OP_W-1:0]     nxt_code;
    logic [vec_pkg::VWIDTH-1:0]   nxt_opa;
    logic [vec_pkg::VWIDTH-1:0]   nxt_opb;
    logic                         nxt_write;
    logic                         nxt_cmp;
    logic                         nxt_illegal;
    logic [vec_pkg::RIDX_W-1:0]   op_rd;
    logic                         op_write;
    logic                         op_cmp;
    logic                         op_illegal;

    assign ins    = instr;
    assign opc    = ins.rform.opcode;
    assign ra_idx = ins.rform.ra;
    assign rb_idx = ins.rform.rb;

    assign imm32   = {{(vec_pkg::DWIDTH-vec_pkg::IMM_W){ins.iform.imm[vec_pkg::IMM_W-1]}},
                      ins.iform.imm};
    assign imm_vec = {vec_pkg::LANES{imm32}};      // Same value in every lane.

    // ##################################################################
    // Decode
    // ##################################################################

    always_comb begin
        nxt_code    = opc;
        nxt_opa     = ra_data;
        nxt_opb     = rb_data;
        nxt_write   = 1'b0;
        nxt_cmp     = 1'b0;
        nxt_illegal = 1'b0;

        case (opc)
            vec_pkg::OP_NOP: nxt_write = 1'b0;
            vec_pkg::OP_LDI: begin
                nxt_code  = vec_pkg::OP_ADD;       // Zero plus immediate.
                nxt_opa   = '0;
                nxt_opb   = imm_vec;
                nxt_write = 1'b1;
            end
            vec_pkg::OP_ADDI: begin
                nxt_code  = vec_pkg::OP_ADD;
                nxt_opb   = imm_vec;
                nxt_write = 1'b1;
            end
            vec_pkg::OP_CMP: nxt_cmp = 1'b1;
            vec_pkg::OP_ADD, vec_pkg::OP_SUB, vec_pkg::OP_MUL, vec_pkg::OP_DIV,
            vec_pkg::OP_AND, vec_pkg::OP_OR, vec_pkg::OP_SHL, vec_pkg::OP_SHR,
            vec_pkg::OP_NOT: begin
                nxt_write = 1'b1;
            end
            default: nxt_illegal = 1'b1;           // Lanes return zero for it.
        endcase
    end

    // ##################################################################
    // Operand stage and class delay
    // ##################################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            op_valid   <= 1'b0;
            op_write   <= 1'b0;
            op_cmp     <= 1'b0;
            op_illegal <= 1'b0;
            wb_write   <= 1'b0;
            wb_cmp     <= 1'b0;
            wb_illegal <= 1'b0;
        end else begin
            op_valid   <= instr_valid;
            op_write   <= instr_valid & nxt_write;
            op_cmp     <= instr_valid & nxt_cmp;
            op_illegal <= instr_valid & nxt_illegal;
            wb_write   <= op_write;                // Aligned with lane results.
            wb_cmp     <= op_cmp;
            wb_illegal <= op_illegal;
        end
    end

    always_ff @(posedge clk) begin
        op_code <= nxt_code;
        opa     <= nxt_opa;
        opb     <= nxt_opb;
        op_rd   <= ins.rform.rd;
        wb_rd   <= op_rd;
    end

endmodule

/* logic/vec_regfile.sv */
`timescale 1ns/1ps

module vec_regfile (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [vec_pkg::RIDX_W-1:0]    ra_idx,
    input  logic [vec_pkg::RIDX_W-1:0]    rb_idx,
    input  logic                          we,
    input  logic [vec_pkg::RIDX_W-1:0]    wr_idx,
    input  logic [vec_pkg::VWIDTH-1:0]    wr_data,
    output logic [vec_pkg::VWIDTH-1:0]    ra_data,
    output logic [vec_pkg::VWIDTH-1:0]    rb_data
);

    logic [vec_pkg::VWIDTH-1:0] regs [vec_pkg::NREGS];

    // ##################################################################
    // Write port
    // ##################################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < vec_pkg::NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Read ports see a write one cycle after it lands.
    assign ra_data = regs[ra_idx];
    assign rb_data = regs[rb_idx];

endmodule

/* logic/vec_writeback.sv */
`timescale 1ns/1ps

module vec_writeback (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [vec_pkg::LANES-1:0]     res_valid,
    input  logic [vec_pkg::VWIDTH-1:0]    lane_res,
    input  logic [vec_pkg::LANES-1:0]     lane_below,
    input  logic [vec_pkg::LANES-1:0]     lane_equal,
    input  logic [vec_pkg::LANES-1:0]     lane_above,
    input  logic [vec_pkg::LANES-1:0]     lane_div_zero,
    input  logic [vec_pkg::RIDX_W-1:0]    wb_rd,
    input  logic                          wb_write,
    input  logic                          wb_cmp,
    input  logic                          wb_illegal,
    output logic                          we,
    output logic [vec_pkg::RIDX_W-1:0]    wr_idx,
    output logic [vec_pkg::VWIDTH-1:0]    wr_data,
    output logic                          done,
    output logic [vec_pkg::RIDX_W-1:0]    done_rd,
    output logic [vec_pkg::VWIDTH-1:0]    done_result,
    output logic [vec_pkg::LANES-1:0]     below_mask,
    output logic [vec_pkg::LANES-1:0]     equal_mask,
    output logic [vec_pkg::LANES-1:0]     above_mask,
    output logic                          div_error,
    output logic                          illegal
);

    logic all_valid;
    logic cmp_hit;

    // Lanes run in lockstep.
    assign all_valid = &res_valid;
    assign cmp_hit   = all_valid & wb_cmp;

    // ##################################################################
    // Register file write, lands with the completion edge
    // ##################################################################

    assign we      = all_valid & wb_write;
    assign wr_idx  = wb_rd;
    assign wr_data = lane_res;

    // ##################################################################
    // Completion outputs
    // ##################################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            done       <= 1'b0;
            div_error  <= 1'b0;
            illegal    <= 1'b0;
            below_mask <= '0;
            equal_mask <= '0;
            above_mask <= '0;
        end else begin
            done       <= all_valid;
            div_error  <= all_valid & (|lane_div_zero);
            illegal    <= all_valid & wb_illegal;
            below_mask <= cmp_hit ? lane_below : '0;    // Masks only for CMP.
            equal_mask <= cmp_hit ? lane_equal : '0;
            above_mask <= cmp_hit ? lane_above : '0;
        end
    end

    always_ff @(posedge clk) begin
        done_rd     <= wb_rd;
        done_result <= lane_res;
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the vector ALU testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module tb_vec_alu -f verilog.f \
    --Mdir obj_dir -o vsim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/vsim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

if ! grep -q ">>> PASS" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi

exit 0

/* vec_lane/ula.sv */
`timescale 1ns/1ps

module ula (
    input  logic [vec_pkg::OP_W-1:0]      op_code,
    input  logic [vec_pkg::DWIDTH-1:0]    operand_a,
    input  logic [vec_pkg::DWIDTH-1:0]    operand_b,
    output logic [vec_pkg::DWIDTH-1:0]    result,
    output logic                          below,
    output logic                          equal,
    output logic                          above,
    output logic                          error_flag
);

    localparam int SH_W = $clog2(vec_pkg::DWIDTH);

    logic shift_ok;

    // Shift amounts of a full word or more flush to zero.
    assign shift_ok = (operand_b < vec_pkg::DWIDTH);

    always_comb begin
        result     = '0;
        below      = 1'b0;
        equal      = 1'b0;
        above      = 1'b0;
        error_flag = 1'b0;

        case (op_code)
            vec_pkg::OP_ADD: begin
                result = operand_a + operand_b;
            end
            vec_pkg::OP_SUB: begin
                result = operand_a - operand_b;
            end
            vec_pkg::OP_MUL: begin
                result = operand_a * operand_b;    // Low word only.
            end
            vec_pkg::OP_DIV: begin
                if (operand_b != '0) begin
                    result = operand_a / operand_b;
                end else begin
                    error_flag = 1'b1;             // Result stays zero.
                end
            end
            vec_pkg::OP_AND: begin
                result = operand_a & operand_b;
            end
            vec_pkg::OP_OR: begin
                result = operand_a | operand_b;
            end
            vec_pkg::OP_NOT: begin
                result = ~operand_a;
            end
            vec_pkg::OP_SHL: begin
                if (shift_ok) begin
                    result = operand_a << operand_b[SH_W-1:0];
                end
            end
            vec_pkg::OP_SHR: begin
                if (shift_ok) begin
                    result = operand_a >> operand_b[SH_W-1:0];
                end
            end
            vec_pkg::OP_CMP: begin
                if (operand_a == operand_b) begin
                    equal = 1'b1;
                end else if (operand_a > operand_b) begin
                    above = 1'b1;                  // Unsigned.
                end else begin
                    below = 1'b1;
                end
            end
            default: begin
                result = '0;                       // NOP and unknown codes.
            end
        endcase
    end

endmodule

/* vec_lane/vec_lane.sv */
`timescale 1ns/1ps

module vec_lane (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          op_valid,
    input  logic [vec_pkg::OP_W-1:0]      op_code,
    input  logic [vec_pkg::DWIDTH-1:0]    opa,
    input  logic [vec_pkg::DWIDTH-1:0]    opb,
    output logic                          res_valid,
    output logic [vec_pkg::DWIDTH-1:0]    res,
    output logic                          below,
    output logic                          equal,
    output logic                          above,
    output logic                          div_zero
);

    logic [vec_pkg::DWIDTH-1:0] alu_res;
    logic                       alu_below;
    logic                       alu_equal;
    logic                       alu_above;
    logic                       alu_err;

    ula i_ula (
        .op_code    (op_code),
        .operand_a  (opa),
        .operand_b  (opb),
        .result     (alu_res),
        .below      (alu_below),
        .equal      (alu_equal),
        .above      (alu_above),
        .error_flag (alu_err)
    );

    // Flags only live for a valid operation.
    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
            below     <= 1'b0;
            equal     <= 1'b0;
            above     <= 1'b0;
            div_zero  <= 1'b0;
        end else begin
            res_valid <= op_valid;
            below     <= op_valid & alu_below;
            equal     <= op_valid & alu_equal;
            above     <= op_valid & alu_above;
            div_zero  <= op_valid & alu_err;
        end
    end

    always_ff @(posedge clk) begin
        res <= alu_res;
    end

endmodule

/* verification/tb_vec_alu.sv */
`timescale 1ns/1ps

module tb_vec_alu;

    localparam int N_RANDOM = 300;
    localparam int DW       = vec_pkg::DWIDTH;

    logic                          clk;
    logic                          rst;
    logic                          instr_valid;
    logic [vec_pkg::ILEN-1:0]      instr;
    logic                          done;
    logic [vec_pkg::RIDX_W-1:0]    done_rd;
    logic [vec_pkg::VWIDTH-1:0]    done_result;
    logic [vec_pkg::LANES-1:0]     below_mask;
    logic [vec_pkg::LANES-1:0]     equal_mask;
    logic [vec_pkg::LANES-1:0]     above_mask;
    logic                          div_error;
    logic                          illegal;

    logic [vec_pkg::VWIDTH-1:0]    model_rf [vec_pkg::NREGS];
    logic [144:0]                  expect_q [$];   // {rd, result, masks, div, illegal}.
    logic [144:0]                  exp_entry;
    integer                        seed;
    int                            errors;
    int                            checks;
    int                            slots;
    int                            cycles;
    logic [31:0]                   rnd;
    logic [vec_pkg::OP_W-1:0]      op;
    logic [vec_pkg::RIDX_W-1:0]    rd;
    logic [vec_pkg::RIDX_W-1:0]    ra;
    logic [vec_pkg::RIDX_W-1:0]    rb;
    logic [vec_pkg::IMM_W-1:0]     imm;
    logic [3:0]                    last1;
    logic [3:0]                    last2;

    vec_alu_top i_vec_alu_top (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .done        (done),
        .done_rd     (done_rd),
        .done_result (done_result),
        .below_mask  (below_mask),
        .equal_mask  (equal_mask),
        .above_mask  (above_mask),
        .div_error   (div_error),
        .illegal     (illegal)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > 2 * slots + 50) begin
            $display("Timeout: no completion of the program after %0d cycles", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    // ##################################################################
    // Instruction builders and reference model
    // ##################################################################

    function automatic vec_pkg::instr_t rtype_word(input logic [vec_pkg::OP_W-1:0] opc,
            input logic [2:0] d, input logic [2:0] a, input logic [2:0] b);
        vec_pkg::instr_t w;
        w              = '0;
        w.rform.opcode = opc;
        w.rform.rd     = d;
        w.rform.ra     = a;
        w.rform.rb     = b;
        return w;
    endfunction

    function automatic vec_pkg::instr_t itype_word(input logic [vec_pkg::OP_W-1:0] opc,
            input logic [2:0] d, input logic [2:0] a, input logic [vec_pkg::IMM_W-1:0] k);
        vec_pkg::instr_t w;
        w              = '0;
        w.iform.opcode = opc;
        w.iform.rd     = d;
        w.iform.ra     = a;
        w.iform.imm    = k;
        return w;
    endfunction

    task automatic predict(input vec_pkg::instr_t w);
        logic [vec_pkg::VWIDTH-1:0]  a;
        logic [vec_pkg::VWIDTH-1:0]  b;
        logic [vec_pkg::VWIDTH-1:0]  res;
        logic [vec_pkg::LANES-1:0]   bl;
        logic [vec_pkg::LANES-1:0]   eq;
        logic [vec_pkg::LANES-1:0]   ab;
        logic [vec_pkg::OP_W-1:0]    opc;
        logic [DW-1:0]               x;
        logic [DW-1:0]               y;
        logic [DW-1:0]               r;
        logic [DW-1:0]               k;
        logic                        dz;
        logic                        ill;
        logic                        wr;
        a   = model_rf[w.rform.ra];
        b   = model_rf[w.rform.rb];
        k   = {{(DW - vec_pkg::IMM_W){w.iform.imm[vec_pkg::IMM_W-1]}}, w.iform.imm};
        opc = w.rform.opcode;
        ill = (opc > vec_pkg::OP_NOT);
        wr  = !ill && (opc != vec_pkg::OP_NOP) && (opc != vec_pkg::OP_CMP);
        res = '0;
        bl  = '0;
        eq  = '0;
        ab  = '0;
        dz  = 1'b0;
        for (int l = 0; l < vec_pkg::LANES; l++) begin
            x = a[l*DW +: DW];
            y = b[l*DW +: DW];
            r = '0;
            case (opc)
                vec_pkg::OP_LDI:  r = k;
                vec_pkg::OP_ADDI: r = x + k;
                vec_pkg::OP_ADD:  r = x + y;
                vec_pkg::OP_SUB:  r = x - y;
                vec_pkg::OP_MUL:  r = x * y;
                vec_pkg::OP_DIV: begin
                    if (y == '0) begin
                        dz = 1'b1;
                    end else begin
                        r = x / y;
                    end
                end
                vec_pkg::OP_AND:  r = x & y;
                vec_pkg::OP_OR:   r = x | y;
                vec_pkg::OP_NOT:  r = ~x;
                vec_pkg::OP_SHL:  r = (y >= 32'd32) ? '0 : (x << y);
                vec_pkg::OP_SHR:  r = (y >= 32'd32) ? '0 : (x >> y);
                vec_pkg::OP_CMP: begin
                    bl[l] = (x < y);
                    eq[l] = (x == y);
                    ab[l] = (x > y);
                end
                default:          r = '0;
            endcase
            res[l*DW +: DW] = r;
        end
        if (wr) begin
            model_rf[w.rform.rd] = res;
        end
        expect_q.push_back({w.rform.rd, res, bl, eq, ab, dz, ill});
    endtask

    task automatic issue_instr(input vec_pkg::instr_t w);
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = w;
        slots++;
        predict(w);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            instr_valid = 1'b0;
            instr       = '0;
        end
    endtask

    task automatic report_mismatch(input string msg);
        errors++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    // ##################################################################
    // Completion checks
    // ##################################################################

    always @(negedge clk) begin
        if (!rst && done) begin
            if (expect_q.size() == 0) begin
                errors++;
                $display("Error at %0t ns: done pulsed with no instruction outstanding", $time);
            end else begin
                exp_entry = expect_q.pop_front();
                checks++;
                assert (done_rd == exp_entry[144:142])
                    else report_mismatch($sformatf("done_rd %0d, expected %0d",
                                                   done_rd, exp_entry[144:142]));
                assert (done_result == exp_entry[141:14])
                    else report_mismatch($sformatf("done_result %h, expected %h",
                                                   done_result, exp_entry[141:14]));
                assert ({below_mask, equal_mask, above_mask} == exp_entry[13:2])
                    else report_mismatch($sformatf("masks %b %b %b, expected %b",
                                         below_mask, equal_mask, above_mask, exp_entry[13:2]));
                assert ({div_error, illegal} == exp_entry[1:0])
                    else report_mismatch($sformatf("div_error,illegal %b%b, expected %b",
                                                   div_error, illegal, exp_entry[1:0]));
            end
        end
    end

    // ##################################################################
    // Programs
    // ##################################################################

    initial begin
        seed        = 32'h83a4d866;
        clk         = 1'b0;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        errors      = 0;
        checks      = 0;
        slots       = 0;
        cycles      = 0;
        for (int i = 0; i < vec_pkg::NREGS; i++) begin
            model_rf[i] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Reset contents, one completion per cycle.
        for (int i = 0; i < vec_pkg::NREGS; i++) begin
            issue_instr(rtype_word(vec_pkg::OP_OR, 3'(i), 3'(i), 3'(i)));
        end
        idle(2);
        issue_instr(itype_word(vec_pkg::OP_LDI, 3'd1, 3'd0, 21'h1ffffb));  // Minus five.
        issue_instr(itype_word(vec_pkg::OP_LDI, 3'd2, 3'd0, 21'h0abcde));
        issue_instr(itype_word(vec_pkg::OP_LDI, 3'd3, 3'd0, 21'h100000));  // Most negative.
        issue_instr(itype_word(vec_pkg::OP_LDI, 3'd5, 3'd0, 21'd33));
        idle(2);
        issue_instr(itype_word(vec_pkg::OP_ADDI, 3'd6, 3'd1, 21'd7));
        issue_instr(itype_word(vec_pkg::OP_ADDI, 3'd7, 3'd2, 21'h1fffff));
        idle(2);
        issue_instr(rtype_word(vec_pkg::OP_DIV, 3'd0, 3'd2, 3'd4));    // Divisor zero.
        issue_instr(rtype_word(vec_pkg::OP_DIV, 3'd0, 3'd3, 3'd6));
        issue_instr(rtype_word(vec_pkg::OP_CMP, 3'd1, 3'd2, 3'd2));
        issue_instr(rtype_word(vec_pkg::OP_CMP, 3'd1, 3'd2, 3'd7));
        issue_instr(rtype_word(vec_pkg::OP_CMP, 3'd1, 3'd7, 3'd2));
        issue_instr(rtype_word(vec_pkg::OP_NOP, 3'd7, 3'd0, 3'd0));
        issue_instr(rtype_word(5'd13, 3'd3, 3'd1, 3'd2));
        issue_instr(rtype_word(5'd31, 3'd6, 3'd1, 3'd2));
        idle(2);
        issue_instr(rtype_word(vec_pkg::OP_SHL, 3'd4, 3'd2, 3'd5));    // Shift of 33.
        issue_instr(rtype_word(vec_pkg::OP_SHR, 3'd4, 3'd1, 3'd5));
        issue_instr(rtype_word(vec_pkg::OP_SHR, 3'd0, 3'd3, 3'd6));
        issue_instr(rtype_word(vec_pkg::OP_MUL, 3'd4, 3'd1, 3'd7));
        idle(2);

        // Random program, sources kept clear of the last two writes.
        last1 = 4'd8;
        last2 = 4'd8;
        for (int n = 0; n < N_RANDOM; n++) begin
            rnd = $random(seed);
            op  = 5'(rnd % 32'd13);
            rd  = rnd[10:8];
            ra  = rnd[13:11];
            rb  = rnd[16:14];
            while ({1'b0, ra} == last1 || {1'b0, ra} == last2) begin
                ra = ra + 3'd1;
            end
            while ({1'b0, rb} == last1 || {1'b0, rb} == last2) begin
                rb = rb + 3'd1;
            end
            rnd = $random(seed);
            imm = rnd[31] ? rnd[20:0] : {15'd0, rnd[5:0]};    // Small values feed shifts.
            if (op == vec_pkg::OP_LDI || op == vec_pkg::OP_ADDI) begin
                issue_instr(itype_word(op, rd, ra, imm));
            end else begin
                issue_instr(rtype_word(op, rd, ra, rb));
            end
            last2 = last1;
            last1 = (op == vec_pkg::OP_NOP || op == vec_pkg::OP_CMP) ? 4'd8 : {1'b0, rd};
        end
        idle(2);

        // Final sweep reads back every register.
        for (int i = 0; i < vec_pkg::NREGS; i++) begin
            issue_instr(rtype_word(vec_pkg::OP_OR, 3'(i), 3'(i), 3'(i)));
        end
        idle(1);
        while (expect_q.size() != 0) begin
            @(negedge clk);
        end

        $display("Run complete: %0d completions checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* verification/vec_alu_chk.sv */
`timescale 1ns/1ps

module vec_alu_chk (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          instr_valid,
    input  logic                          done,
    input  logic [vec_pkg::LANES-1:0]     below_mask,
    input  logic [vec_pkg::LANES-1:0]     equal_mask,
    input  logic [vec_pkg::LANES-1:0]     above_mask,
    input  logic                          div_error,
    input  logic                          illegal
);

    // Sampling edge n gives done after edge n+2, seen at edge n+3.
    a_latency: assert property (@(posedge clk) disable iff (rst)
        done == $past(instr_valid, 3))
        else $error("done does not follow instr_valid by two cycles");

    a_reset: assert property (@(posedge clk)
        rst |=> (!done && !div_error && !illegal && below_mask == '0
                 && equal_mask == '0 && above_mask == '0))
        else $error("completion outputs not low after reset");

    a_onehot: assert property (@(posedge clk) disable iff (rst)
        ((below_mask & equal_mask) | (below_mask & above_mask)
         | (equal_mask & above_mask)) == '0)
        else $error("more than one compare bit set in a lane");

    a_flags: assert property (@(posedge clk) disable iff (rst)
        (div_error || illegal) |-> done)
        else $error("div_error or illegal raised without done");

endmodule

bind vec_alu_top vec_alu_chk i_vec_alu_chk (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .done        (done),
    .below_mask  (below_mask),
    .equal_mask  (equal_mask),
    .above_mask  (above_mask),
    .div_error   (div_error),
    .illegal     (illegal)
);

/* verilog.f */
common/vec_pkg.sv
logic/vec_regfile.sv
vec_lane/ula.sv
vec_lane/vec_lane.sv
logic/vec_issue.sv
logic/vec_writeback.sv
logic/vec_alu_top.sv
verification/vec_alu_chk.sv
verification/tb_vec_alu.sv
